// ==== Makefile ====
# Verilator build and run for the rv_frontend testbench

SIM = obj_dir/Vtb_rv_frontend

# rebuilt only when the file list or a source file changes
$(SIM): rv_frontend.f $(wildcard hw/*.sv verification/*.sv)
	verilator --binary --timing -j 0 --top-module tb_rv_frontend -f rv_frontend.f

# the log must hold the pass line for the run to count as passed
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== hw/rv_frontend.sv ====
// rv64i front end top: fetch and decode stages with jal redirect
`timescale 1ns/1ns

module rv_frontend #(
  // first fetch goes to reset value + 4
  parameter logic [rv_frontend_pkg::PC_WD-1:0] PC_RESETVAL = 64'h0000_0000_7fff_fffc
) (
  input  logic                                      i_clk,
  input  logic                                      i_rst,
  // instruction sram, kept outside the core
  output logic                                      o_inst_sram_ren,
  output logic [rv_frontend_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  input  logic [rv_frontend_pkg::SRAM_DATA_WD-1:0]  i_inst_sram_rdata,
  // decoded item to ex
  input  logic                                      i_es_allowin,
  output logic                                      o_ds_to_es_valid,
  output logic [rv_frontend_pkg::PC_WD-1:0]         o_ds_to_es_pc,
  output logic [rv_frontend_pkg::INST_WD-1:0]       o_ds_to_es_inst,
  output rv_frontend_pkg::inst_class_e              o_ds_to_es_class,
  output logic [63:0]                               o_ds_to_es_imm
);

  import rv_frontend_pkg::*;

  // if to id
  logic               fs_to_ds_valid;
  logic [PC_WD-1:0]   fs_to_ds_pc;
  logic [INST_WD-1:0] fs_to_ds_inst;
  logic               ds_allowin;

  // id to if redirect
  logic               br_taken;
  logic [PC_WD-1:0]   br_target;

  // fetch
  rv_if_stage #(
    .PC_RESETVAL       (PC_RESETVAL)
  ) if_stage_i (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_ds_allowin      (ds_allowin),
    .i_br_taken        (br_taken),
    .i_br_target       (br_target),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds_pc     (fs_to_ds_pc),
    .o_fs_to_ds_inst   (fs_to_ds_inst),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  // decode, also squashes the wrong-path fetch
  rv_id_stage id_stage_i (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_fs_to_ds_valid  (fs_to_ds_valid),
    .i_fs_to_ds_pc     (fs_to_ds_pc),
    .i_fs_to_ds_inst   (fs_to_ds_inst),
    .o_ds_allowin      (ds_allowin),
    .o_br_taken        (br_taken),
    .o_br_target       (br_target),
    .i_es_allowin      (i_es_allowin),
    .o_ds_to_es_valid  (o_ds_to_es_valid),
    .o_ds_to_es_pc     (o_ds_to_es_pc),
    .o_ds_to_es_inst   (o_ds_to_es_inst),
    .o_ds_to_es_class  (o_ds_to_es_class),
    .o_ds_to_es_imm    (o_ds_to_es_imm)
  );

endmodule

// ==== hw/rv_frontend_pkg.sv ====
// rv64i front end shared definitions: widths, major opcodes and instruction classes
package rv_frontend_pkg;

  // datapath widths
  localparam int PC_WD        = 64;
  localparam int INST_WD      = 32;
  // instruction sram, byte address and double-word read data
  localparam int SRAM_ADDR_WD = 32;
  localparam int SRAM_DATA_WD = 64;

  // rv64i major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    LUI       = 7'b0110111,
    AUIPC     = 7'b0010111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    // conditional branches, funct3 picks the compare
    BRANCH    = 7'b1100011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    // register-immediate alu ops
    OP_IMM    = 7'b0010011,
    // 32-bit word forms, rv64 only
    OP_IMM_32 = 7'b0011011,
    // register-register alu ops
    OP        = 7'b0110011,
    OP_32     = 7'b0111011,
    // ecall, ebreak, csr access
    SYSTEM    = 7'b1110011
  } opcode_e;

  // instruction class seen by the back end
  typedef enum logic [3:0] {
    CLS_LUI     = 4'd0,
    CLS_AUIPC   = 4'd1,
    // jal is resolved in id
    CLS_JAL     = 4'd2,
    // jalr and branches need rs1, only classified here
    CLS_JALR    = 4'd3,
    CLS_BRANCH  = 4'd4,
    CLS_LOAD    = 4'd5,
    CLS_STORE   = 4'd6,
    // op_imm and op_imm_32
    CLS_ALU_IMM = 4'd7,
    // op and op_32
    CLS_ALU_REG = 4'd8,
    CLS_SYSTEM  = 4'd9,
    // any opcode not listed above
    CLS_ILLEGAL = 4'd10
  } inst_class_e;

endpackage

// ==== hw/rv_id_stage.sv ====
// instruction decode stage that classifies instructions, builds immediates and resolves jal
`timescale 1ns/1ns

module rv_id_stage (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  // item from if
  input  logic                                  i_fs_to_ds_valid,
  input  logic [rv_frontend_pkg::PC_WD-1:0]     i_fs_to_ds_pc,
  input  logic [rv_frontend_pkg::INST_WD-1:0]   i_fs_to_ds_inst,
  output logic                                  o_ds_allowin,
  // jal redirect to if
  output logic                                  o_br_taken,
  output logic [rv_frontend_pkg::PC_WD-1:0]     o_br_target,
  // item to ex
  input  logic                                  i_es_allowin,
  output logic                                  o_ds_to_es_valid,
  output logic [rv_frontend_pkg::PC_WD-1:0]     o_ds_to_es_pc,
  output logic [rv_frontend_pkg::INST_WD-1:0]   o_ds_to_es_inst,
  output rv_frontend_pkg::inst_class_e          o_ds_to_es_class,
  output logic [63:0]                           o_ds_to_es_imm
);

  import rv_frontend_pkg::*;

  // pipeline register
  logic               ds_valid;
  logic [PC_WD-1:0]   ds_pc;
  logic [INST_WD-1:0] ds_inst;

  // the if item is accepted and not squashed
  logic               ds_load;

  // decode
  opcode_e            opcode;
  inst_class_e        inst_class;

  // immediate formats all sign-extended to 64 bits
  logic [63:0]        imm_i;
  logic [63:0]        imm_s;
  logic [63:0]        imm_b;
  logic [63:0]        imm_u;
  logic [63:0]        imm_j;

  // decode finishes in one cycle so only ex can hold id
  assign o_ds_allowin     = !ds_valid || i_es_allowin;
  assign o_ds_to_es_valid = ds_valid;

  // jal leaving id this cycle redirects if
  assign o_br_taken  = o_ds_to_es_valid && i_es_allowin && (inst_class == CLS_JAL);
  assign o_br_target = ds_pc + imm_j;

  // the if item behind a taken jal is the sequential wrong path
  assign ds_load = i_fs_to_ds_valid && o_ds_allowin && !o_br_taken;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      // squashed item just drops out
      ds_valid <= i_fs_to_ds_valid && !o_br_taken;
    end
  end

  // payload only moves on a real transfer
  always_ff @(posedge i_clk) begin
    if (ds_load) begin
      ds_pc   <= i_fs_to_ds_pc;
      ds_inst <= i_fs_to_ds_inst;
    end
  end

  // major opcode
  assign opcode = opcode_e'(ds_inst[6:0]);

  always_comb begin
    case (opcode)
      LUI:       inst_class = CLS_LUI;
      AUIPC:     inst_class = CLS_AUIPC;
      JAL:       inst_class = CLS_JAL;
      JALR:      inst_class = CLS_JALR;
      BRANCH:    inst_class = CLS_BRANCH;
      LOAD:      inst_class = CLS_LOAD;
      STORE:     inst_class = CLS_STORE;
      OP_IMM:    inst_class = CLS_ALU_IMM;
      OP_IMM_32: inst_class = CLS_ALU_IMM;
      OP:        inst_class = CLS_ALU_REG;
      OP_32:     inst_class = CLS_ALU_REG;
      SYSTEM:    inst_class = CLS_SYSTEM;
      // unknown encodings
      default:   inst_class = CLS_ILLEGAL;
    endcase
  end

  // i-type from inst[31:20]
  assign imm_i = {{52{ds_inst[31]}}, ds_inst[31:20]};
  // s-type split around the rd field
  assign imm_s = {{52{ds_inst[31]}}, ds_inst[31:25], ds_inst[11:7]};
  // b-type in 2-byte steps
  assign imm_b = {{51{ds_inst[31]}}, ds_inst[31], ds_inst[7], ds_inst[30:25],
                  ds_inst[11:8], 1'b0};
  // u-type takes the upper 20 bits and sign-extends past bit 31
  assign imm_u = {{32{ds_inst[31]}}, ds_inst[31:12], 12'b0};
  // j-type in 2-byte steps
  assign imm_j = {{43{ds_inst[31]}}, ds_inst[31], ds_inst[19:12], ds_inst[20],
                  ds_inst[30:21], 1'b0};

  // immediate by class
  always_comb begin
    case (inst_class)
      CLS_LUI,
      CLS_AUIPC:   o_ds_to_es_imm = imm_u;
      CLS_JAL:     o_ds_to_es_imm = imm_j;
      CLS_BRANCH:  o_ds_to_es_imm = imm_b;
      CLS_STORE:   o_ds_to_es_imm = imm_s;
      CLS_LOAD,
      CLS_JALR,
      CLS_ALU_IMM,
      CLS_SYSTEM:  o_ds_to_es_imm = imm_i;
      // register ops and illegal carry no immediate
      default:     o_ds_to_es_imm = '0;
    endcase
  end

  assign o_ds_to_es_pc    = ds_pc;
  assign o_ds_to_es_inst  = ds_inst;
  assign o_ds_to_es_class = inst_class;

endmodule

// ==== hw/rv_if_stage.sv ====
// instruction fetch stage with pc register, next-pc select, sram read and if-to-id handshake
`timescale 1ns/1ns

module rv_if_stage #(
  parameter logic [rv_frontend_pkg::PC_WD-1:0] PC_RESETVAL = '0
) (
  input  logic                                      i_clk,
  input  logic                                      i_rst,
  // id can take the next item
  input  logic                                      i_ds_allowin,
  // jal redirect from id
  input  logic                                      i_br_taken,
  input  logic [rv_frontend_pkg::PC_WD-1:0]         i_br_target,
  // item to id
  output logic                                      o_fs_to_ds_valid,
  output logic [rv_frontend_pkg::PC_WD-1:0]         o_fs_to_ds_pc,
  output logic [rv_frontend_pkg::INST_WD-1:0]       o_fs_to_ds_inst,
  // instruction sram
  output logic                                      o_inst_sram_ren,
  output logic [rv_frontend_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  input  logic [rv_frontend_pkg::SRAM_DATA_WD-1:0]  i_inst_sram_rdata
);

  import rv_frontend_pkg::*;

  // pre-if has a new fetch request whenever the core is out of reset
  logic               to_fs_valid;

  // if stage state
  logic               fs_valid;
  logic               fs_allowin;
  logic [PC_WD-1:0]   fs_pc;

  // next pc candidates
  logic [PC_WD-1:0]   seq_pc;
  logic [PC_WD-1:0]   next_pc;

  // first request goes out in the first cycle after reset
  assign to_fs_valid = ~i_rst;

  // empty, or the held item leaves this cycle
  // fetch always completes in one cycle
  assign fs_allowin = !fs_valid || i_ds_allowin;

  assign o_fs_to_ds_valid = fs_valid;

  // sequential path unless id resolved a jal this cycle
  assign seq_pc  = fs_pc + PC_WD'(4);
  assign next_pc = i_br_taken ? i_br_target : seq_pc;

  // valid flag
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= to_fs_valid;
    end
  end

  // pc moves together with each new sram request
  // reset value sits one word before the boot address
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_pc <= PC_RESETVAL;
    end else if (to_fs_valid && fs_allowin) begin
      fs_pc <= next_pc;
    end
  end

  // read issues with the pc load and data comes back next cycle
  // no request while stalled so the sram output holds
  assign o_inst_sram_ren  = to_fs_valid && fs_allowin;
  assign o_inst_sram_addr = next_pc[SRAM_ADDR_WD-1:0];

  // pc[2] picks the 32-bit half of the 64-bit read word
  // bit 2 set selects the low half
  always_comb begin
    if (fs_pc[2]) begin
      o_fs_to_ds_inst = i_inst_sram_rdata[INST_WD-1:0];
    end else begin
      o_fs_to_ds_inst = i_inst_sram_rdata[SRAM_DATA_WD-1:INST_WD];
    end
  end

  assign o_fs_to_ds_pc = fs_pc;

endmodule

// ==== rv_frontend.f ====
hw/rv_frontend_pkg.sv
hw/rv_if_stage.sv
hw/rv_id_stage.sv
hw/rv_frontend.sv
verification/tb_clk_gen.sv
verification/tb_rv_frontend.sv

// ==== verification/tb_clk_gen.sv ====
// testbench clock and reset source: free-running clock plus a reset held for a set number of cycles
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int CLK_PERIOD = 40,
  parameter int RST_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  // released just after an edge, like the other stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

// ==== verification/tb_rv_frontend.sv ====
// rv_frontend testbench that runs a random program with ex stalls against a reference walk
`timescale 1ns/1ns

module tb_rv_frontend;

  import rv_frontend_pkg::*;

  localparam int          CLK_PERIOD  = 40;
  localparam int          RST_CYCLES  = 8;
  localparam int          MEM_WORDS   = 1024;
  localparam logic [63:0] BOOT_PC     = 64'h0000_0000_8000_0000;
  // words from the boot address on that hold no jal
  localparam int          SEQ_WORDS   = 64;
  localparam int          JAL_ITEMS   = 200;
  localparam int          BP_ITEMS    = 400;
  // longest run of ex stall cycles
  localparam int          MAX_STALL   = 3;
  localparam int          TOTAL_ITEMS = SEQ_WORDS + JAL_ITEMS + BP_ITEMS;
  // per item up to MAX_STALL stall cycles plus a jal bubble, the transfer and a spare
  localparam int          WATCHDOG_NS =
    (RST_CYCLES + 16 + TOTAL_ITEMS * (MAX_STALL + 3)) * CLK_PERIOD;

  logic                    clk;
  logic                    rst;
  logic                    inst_sram_ren;
  logic [SRAM_ADDR_WD-1:0] inst_sram_addr;
  logic [SRAM_DATA_WD-1:0] inst_sram_rdata;
  logic                    es_allowin;
  logic                    ds_to_es_valid;
  logic [PC_WD-1:0]        ds_to_es_pc;
  logic [INST_WD-1:0]      ds_to_es_inst;
  inst_class_e             ds_to_es_class;
  logic [63:0]             ds_to_es_imm;

  // program, one instruction per entry
  logic [31:0]             mem [0:MEM_WORDS-1];
  integer                  seed;

  // back-pressure driver
  logic                    bp_enable;
  logic [31:0]             bp_rand;
  int                      stall_run;

  // reference walk
  logic [63:0]             model_pc;
  logic [63:0]             first_pc;
  logic                    prev_jal;
  logic [63:0]             prev_pc;
  logic [15:0]             classes_seen;

  // fetch address model
  logic [SRAM_ADDR_WD-1:0] req_addr;
  logic [SRAM_ADDR_WD-1:0] exp_addr;

  // outputs seen at the last falling edge
  logic                    last_rst;
  logic                    last_valid;
  logic                    last_allow;
  logic [63:0]             last_pc;
  logic [31:0]             last_inst;
  inst_class_e             last_class;
  logic [63:0]             last_imm;

  // bookkeeping
  int                      item_count;
  int                      jal_count;
  int                      stall_count;
  int                      decode_errs;
  int                      test_errs;
  int                      total_errs;
  int                      test_num;
  int                      tests_failed;

  tb_clk_gen #(
    .CLK_PERIOD (CLK_PERIOD),
    .RST_CYCLES (RST_CYCLES)
  ) clk_gen_i (
    .o_clk (clk),
    .o_rst (rst)
  );

  rv_frontend dut_i (
    .i_clk             (clk),
    .i_rst             (rst),
    .o_inst_sram_ren   (inst_sram_ren),
    .o_inst_sram_addr  (inst_sram_addr),
    .i_inst_sram_rdata (inst_sram_rdata),
    .i_es_allowin      (es_allowin),
    .o_ds_to_es_valid  (ds_to_es_valid),
    .o_ds_to_es_pc     (ds_to_es_pc),
    .o_ds_to_es_inst   (ds_to_es_inst),
    .o_ds_to_es_class  (ds_to_es_class),
    .o_ds_to_es_imm    (ds_to_es_imm)
  );

  // class from the major opcode field
  function automatic inst_class_e model_class(input logic [31:0] inst);
    case (inst[6:0])
      LUI:              return CLS_LUI;
      AUIPC:            return CLS_AUIPC;
      JAL:              return CLS_JAL;
      JALR:             return CLS_JALR;
      BRANCH:           return CLS_BRANCH;
      LOAD:             return CLS_LOAD;
      STORE:            return CLS_STORE;
      OP_IMM, OP_IMM_32: return CLS_ALU_IMM;
      OP, OP_32:        return CLS_ALU_REG;
      SYSTEM:           return CLS_SYSTEM;
      default:          return CLS_ILLEGAL;
    endcase
  endfunction

  // immediate per the isa formats with the sign taken from inst[31] by arithmetic shifts
  function automatic logic [63:0] model_imm(input logic [31:0] inst, input inst_class_e cls);
    logic signed [63:0] w;
    logic [63:0]        sgn;
    logic [63:0]        imm;
    w = 64'($signed(inst));
    case (cls)
      CLS_LUI, CLS_AUIPC: imm = (w >>> 12) << 12;
      CLS_JAL: begin
        sgn = w >>> 31;
        imm = (sgn << 20) | (64'(inst[19:12]) << 12) |
              (64'(inst[20]) << 11) | (64'(inst[30:21]) << 1);
      end
      CLS_BRANCH: begin
        sgn = w >>> 31;
        imm = (sgn << 12) | (64'(inst[7]) << 11) |
              (64'(inst[30:25]) << 5) | (64'(inst[11:8]) << 1);
      end
      CLS_STORE: begin
        sgn = w >>> 25;
        imm = (sgn << 5) | 64'(inst[11:7]);
      end
      CLS_LOAD, CLS_JALR, CLS_ALU_IMM, CLS_SYSTEM: imm = w >>> 20;
      default: imm = '0;
    endcase
    return imm;
  endfunction

  // non-jal opcodes in a fixed order
  function automatic logic [6:0] seq_opcode(input int k);
    case (k)
      0:       return LUI;
      1:       return AUIPC;
      2:       return JALR;
      3:       return BRANCH;
      4:       return LOAD;
      5:       return STORE;
      6:       return OP_IMM;
      7:       return OP_IMM_32;
      8:       return OP;
      9:       return OP_32;
      default: return SYSTEM;
    endcase
  endfunction

  // j-type encoding of a byte offset
  function automatic logic [31:0] make_jal(input int off, input logic [4:0] rd);
    logic [20:0] im;
    im = off[20:0];
    return {im[20], im[10:1], im[11], im[19:12], rd, JAL};
  endfunction

  // kind 0..10 is a legal opcode, 11 illegal and 12 jal
  task automatic fill_program();
    logic [31:0] r;
    logic [6:0]  op;
    int          kind;
    int          sel;
    int          off;
    for (int i = 0; i < MEM_WORDS; i++) begin
      r = $random(seed);
      if (i < SEQ_WORDS) begin
        // every non-jal class shows up in the boot region
        kind = i % 12;
      end else begin
        sel = $random(seed) & 15;
        if (sel < 4) kind = 12;
        else if (sel == 4) kind = 11;
        else kind = sel % 11;
      end
      if (kind == 12) begin
        // 1 to 32 words in either direction
        off = (int'(r[4:0]) + 1) * 4;
        if (r[5]) off = -off;
        mem[i] = make_jal(off, r[11:7]);
      end else if (kind == 11) begin
        op = r[6:0];
        while (model_class({25'b0, op}) != CLS_ILLEGAL) op = op + 7'd1;
        mem[i] = {r[31:7], op};
      end else begin
        mem[i] = {r[31:7], seq_opcode(kind)};
      end
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("CHECK FAILED %s: got %h, expected %h at %0t ns", name, got, exp, $time);
    test_errs++;
    total_errs++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s at %0t ns", msg, $time);
    test_errs++;
    total_errs++;
  endtask

  // one accepted item against the next model entry
  task automatic check_transfer();
    logic [31:0] exp_inst;
    inst_class_e exp_cls;
    logic [63:0] exp_imm;
    exp_inst = mem[model_pc[11:2]];
    exp_cls  = model_class(exp_inst);
    exp_imm  = model_imm(exp_inst, exp_cls);
    if (item_count == 0) first_pc = ds_to_es_pc;
    if (ds_to_es_pc !== model_pc) report_mismatch("o_ds_to_es_pc", ds_to_es_pc, model_pc);
    if (ds_to_es_inst !== exp_inst) begin
      report_mismatch("o_ds_to_es_inst", 64'(ds_to_es_inst), 64'(exp_inst));
    end
    if (ds_to_es_class !== exp_cls) begin
      decode_errs++;
      report_mismatch("o_ds_to_es_class", 64'(ds_to_es_class), 64'(exp_cls));
    end
    if (ds_to_es_imm !== exp_imm) begin
      decode_errs++;
      report_mismatch("o_ds_to_es_imm", ds_to_es_imm, exp_imm);
    end
    // fall-through of a taken jal must never leave id
    if (prev_jal && ds_to_es_pc === prev_pc + 64'd4 && model_pc !== prev_pc + 64'd4) begin
      report_error($sformatf("wrong-path pc %h came out after the jal at pc %h",
                             ds_to_es_pc, prev_pc));
    end
    prev_jal = (exp_cls == CLS_JAL);
    prev_pc  = model_pc;
    if (exp_cls == CLS_JAL) begin
      jal_count++;
      model_pc = model_pc + exp_imm;
    end else begin
      model_pc = model_pc + 64'd4;
    end
    classes_seen[exp_cls] = 1'b1;
    item_count++;
  endtask

  // item refused by ex last cycle must sit unchanged
  task automatic check_hold();
    stall_count++;
    if (ds_to_es_valid !== 1'b1) report_mismatch("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd1);
    if (ds_to_es_pc !== last_pc) report_mismatch("o_ds_to_es_pc", ds_to_es_pc, last_pc);
    if (ds_to_es_inst !== last_inst) begin
      report_mismatch("o_ds_to_es_inst", 64'(ds_to_es_inst), 64'(last_inst));
    end
    if (ds_to_es_class !== last_class) begin
      report_mismatch("o_ds_to_es_class", 64'(ds_to_es_class), 64'(last_class));
    end
    if (ds_to_es_imm !== last_imm) report_mismatch("o_ds_to_es_imm", ds_to_es_imm, last_imm);
  endtask

  task automatic wait_items(input int n);
    while (item_count < n) @(posedge clk);
  endtask

  task automatic end_test(input string name, input int errs);
    test_num++;
    if (errs == 0) begin
      $display("test %0d %s: pass, %0d items out so far", test_num, name, item_count);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL, %0d errors", test_num, name, errs);
    end
    test_errs = 0;
  endtask

  // sram model reads the double word at addr[11:3] and bit 2 set means the low half
  always @(posedge clk) begin
    if (inst_sram_ren) begin
      inst_sram_rdata <= {mem[{inst_sram_addr[11:3], 1'b0}], mem[{inst_sram_addr[11:3], 1'b1}]};
    end
  end

  // ex ready changes just after each rising edge
  always @(posedge clk) begin
    #1;
    if (bp_enable) begin
      bp_rand = $random(seed);
      if (stall_run >= MAX_STALL || bp_rand[0]) begin
        es_allowin = 1'b1;
        stall_run  = 0;
      end else begin
        es_allowin = 1'b0;
        stall_run++;
      end
    end else begin
      es_allowin = 1'b1;
      stall_run  = 0;
    end
  end

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst) begin
      if (ds_to_es_valid !== 1'b0) begin
        report_mismatch("o_ds_to_es_valid", 64'(ds_to_es_valid), 64'd0);
      end
      if (inst_sram_ren !== 1'b0) report_mismatch("o_inst_sram_ren", 64'(inst_sram_ren), 64'd0);
      last_valid = 1'b0;
    end else begin
      // first fetch goes out right after reset
      if (last_rst && inst_sram_ren !== 1'b1) begin
        report_mismatch("o_inst_sram_ren", 64'(inst_sram_ren), 64'd1);
      end
      if (last_valid && !last_allow) check_hold();
      if (ds_to_es_valid && es_allowin) check_transfer();
      // each request follows the last one by 4 unless a jal redirects it
      if (inst_sram_ren) begin
        if (ds_to_es_valid && es_allowin && prev_jal) begin
          exp_addr = model_pc[SRAM_ADDR_WD-1:0];
        end else begin
          exp_addr = req_addr + 32'd4;
        end
        if (inst_sram_addr !== exp_addr) begin
          report_mismatch("o_inst_sram_addr", 64'(inst_sram_addr), 64'(exp_addr));
        end
        req_addr = exp_addr;
      end
      // a stalled id keeps if full so no new read goes out
      if (ds_to_es_valid && !es_allowin && inst_sram_ren) begin
        report_error("sram read issued while ex held the id item");
      end
      last_valid = ds_to_es_valid;
      last_allow = es_allowin;
      last_pc    = ds_to_es_pc;
      last_inst  = ds_to_es_inst;
      last_class = ds_to_es_class;
      last_imm   = ds_to_es_imm;
    end
    last_rst = rst;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns with %0d items out", WATCHDOG_NS, item_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed            = 32'hb170d57e;
    es_allowin      = 1'b1;
    inst_sram_rdata = '0;
    bp_enable       = 1'b0;
    stall_run       = 0;
    model_pc        = BOOT_PC;
    first_pc        = '0;
    prev_jal        = 1'b0;
    prev_pc         = '0;
    classes_seen    = '0;
    req_addr        = BOOT_PC[SRAM_ADDR_WD-1:0] - 32'd4;
    exp_addr        = '0;
    last_rst        = 1'b1;
    last_valid      = 1'b0;
    last_allow      = 1'b1;
    item_count      = 0;
    jal_count       = 0;
    stall_count     = 0;
    decode_errs     = 0;
    test_errs       = 0;
    total_errs      = 0;
    test_num        = 0;
    tests_failed    = 0;
    fill_program();

    // quiet reset and the boot address first
    wait_items(1);
    if (first_pc !== BOOT_PC) report_mismatch("o_ds_to_es_pc", first_pc, BOOT_PC);
    end_test("reset", test_errs);

    // boot region with ex always ready
    wait_items(SEQ_WORDS);
    end_test("sequential stream", test_errs);

    wait_items(SEQ_WORDS + JAL_ITEMS);
    if (jal_count == 0) report_error("no jal reached the id output");
    end_test("jal redirect", test_errs);

    bp_enable = 1'b1;
    wait_items(TOTAL_ITEMS);
    if (stall_count == 0) report_error("ex never stalled a valid item");
    end_test("back-pressure", test_errs);

    // decode was checked per item so only class coverage is left
    for (int c = 0; c <= 10; c++) begin
      if (!classes_seen[c]) report_error($sformatf("class %0d never came out of id", c));
    end
    end_test("decode", test_errs + decode_errs);

    $display("summary: %0d tests, %0d failed, %0d items checked, %0d errors",
             test_num, tests_failed, item_count, total_errs);
    if (total_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
